//--- Makefile
# Verilator build and run of the ALU testbench
# Run from the project root, the testbench opens sim/alu_input.txt by relative path

VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/alu_input.txt
// Columns in hex: opcode index, operand A, operand B, expected result, expected cmp_result
// cmp_result is A == B for every opcode that is not a branch compare
00 0f0f00ff 00ffff0f 000f000f 0
05 12345678 12345678 ffffffff 1
03 ffff0000 0f0f0f0f f0f00000 0
04 00000000 0000ffff ffff0000 0
06 ffffffff 00000001 00000000 0
06 7fffffff 00000001 80000000 0
07 00000000 00000001 ffffffff 0
08 00000001 00000024 00000010 0
09 80000000 0000001f 00000001 0
0a 80000000 00000004 f8000000 0
0a 7ffffff0 00000024 07ffffff 0
0b 80000001 00000001 00000003 0
0c 00000001 00000004 10000000 0
0d 00000000 0000003f 80000000 0
0e ffffffff 00000000 fffffffe 0
0f 0000000f 00000023 00000007 0
10 00000010 00000004 00000001 0
11 00000005 00000005 00000000 1
12 00000005 00000005 00000000 0
13 ffffffff 00000001 00000000 1
14 ffffffff 00000001 00000000 0
15 80000000 7fffffff 00000000 0
16 80000000 7fffffff 00000000 1
17 ffffffff 00000000 00000001 0
18 ffffffff 00000000 00000000 0
19 ffffffff 00000001 ffffffff 0
1a ffffffff 00000001 00000001 0
1b 80000000 00000000 00000000 0
1c 80000000 00000000 80000000 0
1d 00000003 00000001 00000007 0
1f 10000000 00000005 80000005 0
20 00000000 00000000 00000020 1
20 00010000 00000000 0000000f 0
21 00000000 ffffffff 00000020 0
22 ffffffff 00000000 00000020 0
23 00100001 00000000 00ff00ff 0
24 12345678 00000000 78563412 0
25 00000080 00000000 ffffff80 0
27 ffff8000 00000000 00008000 0

//--- sim/alu_tb.sv
// Reads vectors from sim/alu_input.txt, so the simulator must run from the project root
// Drives on the falling edge and checks each response one cycle after its request
`timescale 1ns/1ps

module alu_tb;
  import alu_pkg::*;

  localparam int MAX_VECTORS    = 64;
  localparam int TIMEOUT_CYCLES = 20;

  logic     clk;
  logic     reset_i;
  logic     valid_i;
  alu_req_t req_i;
  logic     valid_o;
  alu_rsp_t rsp_o;

  // Vector storage, filled once from the data file
  logic [5:0] vec_op  [MAX_VECTORS];
  word_t      vec_a   [MAX_VECTORS];
  word_t      vec_b   [MAX_VECTORS];
  word_t      vec_res [MAX_VECTORS];
  logic       vec_cmp [MAX_VECTORS];
  int         num_vectors;

  // Per-test error count and overall tallies
  int test_errors;
  int tests_passed;
  int tests_failed;

  alu_top #(
    .zbs_en (1'b1)
  ) alu_top_inst (
    .clk_i   (clk),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

  // 8 ns clock
  always begin
    #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Lines that do not scan as five hex fields are comments
  task automatic load_vectors();
    int                 fd;
    int                 fields;
    logic [8*160-1:0]   line;
    logic [31:0]        f_op;
    logic [31:0]        f_a;
    logic [31:0]        f_b;
    logic [31:0]        f_res;
    logic [31:0]        f_cmp;
    fd = $fopen("sim/alu_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/alu_input.txt");
    end else begin
      while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
        line = '0;
        if ($fgets(line, fd) > 0) begin
          fields = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_cmp);
          if (fields == 5) begin
            vec_op[num_vectors]  = f_op[5:0];
            vec_a[num_vectors]   = f_a;
            vec_b[num_vectors]   = f_b;
            vec_res[num_vectors] = f_res;
            vec_cmp[num_vectors] = f_cmp[0];
            num_vectors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_response(input int idx);
    check_value("rsp_o.result", vec_res[idx], rsp_o.result);
    check_value("rsp_o.cmp_result", 32'(vec_cmp[idx]), 32'(rsp_o.cmp_result));
    // Healthy adder copies never disagree
    check_value("rsp_o.alu_err", 32'd0, 32'(rsp_o.alu_err));
  endtask

  task automatic drive_request(input int idx);
    valid_i         = 1'b1;
    req_i.op        = alu_op_e'(vec_op[idx]);
    req_i.operand_a = vec_a[idx];
    req_i.operand_b = vec_b[idx];
  endtask

  // Polls on falling edges until valid_o rises
  task automatic wait_for_valid();
    int cycles;
    cycles = 0;
    while (valid_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (valid_o !== 1'b1) begin
      $display("Timeout: valid_o did not rise within %0d cycles", TIMEOUT_CYCLES);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    clk          = 1'b0;
    reset_i      = 1'b1;
    valid_i      = 1'b0;
    req_i        = '0;
    num_vectors  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;

    load_vectors();
    if (num_vectors == 0) begin
      $display("The vector file holds no vectors");
      tests_failed++;
    end

    // Reset held for 5 cycles, released on a falling edge
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Nothing valid and no fault before the first request
    test_errors = 0;
    @(negedge clk);
    check_value("valid_o", 32'd0, 32'(valid_o));
    check_value("rsp_o.alu_err", 32'd0, 32'(rsp_o.alu_err));
    finish_test("reset state");

    // One request at a time
    for (int i = 0; i < num_vectors; i++) begin
      test_errors = 0;
      @(negedge clk);
      drive_request(i);
      @(negedge clk);
      valid_i = 1'b0;
      wait_for_valid();
      check_response(i);
      finish_test($sformatf("vector %0d, opcode %0d", i, vec_op[i]));
    end

    // Back-to-back, each response due exactly one cycle after its request
    test_errors = 0;
    @(negedge clk);
    for (int i = 0; i < num_vectors; i++) begin
      drive_request(i);
      @(negedge clk);
      check_value("valid_o", 32'd1, 32'(valid_o));
      check_response(i);
    end
    valid_i = 1'b0;
    @(negedge clk);
    check_value("valid_o", 32'd0, 32'(valid_o));
    finish_test("back-to-back burst");

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src/alu_adder.sv
// Combinational add/subtract, zero cycles of latency
// The fault flag only compares the two copies and says nothing about which is wrong
`timescale 1ns/1ps

module alu_adder (
  input  alu_pkg::alu_op_e op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  output alu_pkg::word_t   sum_o,
  output logic             mismatch_o
);
  import alu_pkg::*;

  logic            subtract;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   adder_in_b;
  logic [XLEN+1:0] adder_sum_ext;
  logic            subtract_dmr;
  word_t           sum_dmr;

  // Main copy, carry-in rides in the extra low bit
  assign subtract      = (op_i == ALU_SUB);
  assign adder_in_a    = {operand_a_i, 1'b1};
  assign adder_in_b    = {(subtract ? ~operand_b_i : operand_b_i), subtract};
  assign adder_sum_ext = adder_in_a + adder_in_b;
  assign sum_o         = adder_sum_ext[XLEN:1];

  // Second copy, built a different way so the two do not share logic
  assign subtract_dmr = op_i inside {ALU_SUB};
  assign sum_dmr      = subtract_dmr ? (operand_a_i - operand_b_i)
                                     : (operand_a_i + operand_b_i);

  // Fault when the copies disagree
  assign mismatch_o = (sum_o != sum_dmr);

  // With known inputs the fault flag must resolve
  always_comb begin
    if (!$isunknown({op_i, operand_a_i, operand_b_i})) begin
      assert (!$isunknown(mismatch_o))
        else $error("adder mismatch flag unknown");
    end
  end

endmodule

//--- src/alu_bitcount.sv
// Counts are unsigned and reach 32 for a zero operand (CLZ, CTZ) or all ones (CPOP)
`timescale 1ns/1ps

module alu_bitcount (
  input  alu_pkg::alu_op_e               op_i,
  input  alu_pkg::word_t                 operand_a_i,
  output logic [alu_pkg::CNT_W-1:0]      count_o
);
  import alu_pkg::*;

  word_t            operand_rev;
  word_t            scan_data;
  logic [CNT_W-1:0] ff1_count;
  logic [CNT_W-1:0] pop_count;

  ////////////////////////////////////////////////////////////////////////////
  // Find first one

  // CLZ scans the bit-reversed operand from the bottom
  assign operand_rev = {<<{operand_a_i}};
  assign scan_data   = (op_i == ALU_B_CTZ) ? operand_a_i : operand_rev;

  // Priority encoder, lowest set bit wins
  always_comb begin
    // No one found gives the full width
    ff1_count = CNT_W'(XLEN);
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (scan_data[i]) begin
        ff1_count = CNT_W'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Population count

  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + CNT_W'(operand_a_i[i]);
    end
  end

  assign count_o = (op_i == ALU_B_CPOP) ? pop_count : ff1_count;

  // Neither path can go past the word width
  always_comb begin
    if (!$isunknown(operand_a_i)) begin
      assert (count_o <= CNT_W'(XLEN))
        else $error("bit count above word width");
    end
  end

endmodule

//--- src/alu_compare.sv
// For opcodes that are not branches the branch result is plain equality
// Signedness follows the opcode; LT, GE, SLT, MIN and MAX are signed
`timescale 1ns/1ps

module alu_compare (
  input  alu_pkg::alu_op_e op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  output logic             cmp_result_o,
  output logic             less_o,
  output alu_pkg::word_t   min_o,
  output alu_pkg::word_t   max_o
);
  import alu_pkg::*;

  logic is_signed;
  logic is_equal;
  logic is_greater;

  assign is_signed = op_i inside {ALU_LT, ALU_GE, ALU_SLT, ALU_B_MIN, ALU_B_MAX};
  assign is_equal  = (operand_a_i == operand_b_i);

  // One extra bit makes one signed compare cover both forms
  assign is_greater = $signed({operand_a_i[XLEN-1] & is_signed, operand_a_i}) >
                      $signed({operand_b_i[XLEN-1] & is_signed, operand_b_i});

  // Strictly less than, shared by LT/LTU branches and SLT/SLTU
  assign less_o = !(is_greater || is_equal);

  // Branch outcome
  always_comb begin
    cmp_result_o = is_equal;
    unique case (op_i)
      ALU_EQ:          cmp_result_o = is_equal;
      ALU_NE:          cmp_result_o = !is_equal;
      ALU_LT, ALU_LTU: cmp_result_o = less_o;
      ALU_GE, ALU_GEU: cmp_result_o = is_greater || is_equal;
      default: ;
    endcase
  end

  // Min and max, A wins on a tie
  assign min_o = is_greater ? operand_b_i : operand_a_i;
  assign max_o = is_greater ? operand_a_i : operand_b_i;

endmodule

//--- src/alu_pkg.sv
// Opcode values are sequential from zero so vector files can give them by index
// Word width is fixed at 32 bits and the count width must hold the value 32
package alu_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Count results reach 32 for an all-zero or all-one operand
  localparam int unsigned CNT_W = 6;

  typedef logic [XLEN-1:0] word_t;

  typedef enum logic [5:0] {
    // Base logical ops
    ALU_AND      = 6'd0,
    ALU_OR       = 6'd1,
    ALU_XOR      = 6'd2,
    // Zbb logical ops with inverted operand B
    ALU_B_ANDN   = 6'd3,
    ALU_B_ORN    = 6'd4,
    ALU_B_XNOR   = 6'd5,
    // Adder
    ALU_ADD      = 6'd6,
    ALU_SUB      = 6'd7,
    // Shifts and rotates
    ALU_SLL      = 6'd8,
    ALU_SRL      = 6'd9,
    ALU_SRA      = 6'd10,
    ALU_B_ROL    = 6'd11,
    ALU_B_ROR    = 6'd12,
    // Zbs single-bit ops
    ALU_B_BSET   = 6'd13,
    ALU_B_BCLR   = 6'd14,
    ALU_B_BINV   = 6'd15,
    ALU_B_BEXT   = 6'd16,
    // Branch compares, result on cmp_result only
    ALU_EQ       = 6'd17,
    ALU_NE       = 6'd18,
    ALU_LT       = 6'd19,
    ALU_LTU      = 6'd20,
    ALU_GE       = 6'd21,
    ALU_GEU      = 6'd22,
    // Set-less-than and min/max
    ALU_SLT      = 6'd23,
    ALU_SLTU     = 6'd24,
    ALU_B_MIN    = 6'd25,
    ALU_B_MINU   = 6'd26,
    ALU_B_MAX    = 6'd27,
    ALU_B_MAXU   = 6'd28,
    // Zba shift-and-add
    ALU_B_SH1ADD = 6'd29,
    ALU_B_SH2ADD = 6'd30,
    ALU_B_SH3ADD = 6'd31,
    // Bit counts
    ALU_B_CLZ    = 6'd32,
    ALU_B_CTZ    = 6'd33,
    ALU_B_CPOP   = 6'd34,
    // Byte ops and extensions
    ALU_B_ORC_B  = 6'd35,
    ALU_B_REV8   = 6'd36,
    ALU_B_SEXT_B = 6'd37,
    ALU_B_SEXT_H = 6'd38,
    ALU_B_ZEXT_H = 6'd39
  } alu_op_e;

  // One request per valid strobe
  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  // Registered response
  typedef struct packed {
    word_t result;
    logic  cmp_result;
    logic  alu_err;
  } alu_rsp_t;

endpackage

//--- src/alu_result_stage.sv
// One register stage, no back-pressure; a request is taken on every edge with valid_i
// The response holds its last value while valid_i is low
`timescale 1ns/1ps

module alu_result_stage #(
  parameter bit zbs_en = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          valid_i,
  input  alu_pkg::alu_req_t             req_i,
  input  alu_pkg::word_t                sum_i,
  input  logic                          mismatch_i,
  input  alu_pkg::word_t                shift_result_i,
  input  logic                          cmp_result_i,
  input  logic                          less_i,
  input  alu_pkg::word_t                min_i,
  input  alu_pkg::word_t                max_i,
  input  logic [alu_pkg::CNT_W-1:0]     count_i,
  output logic                          valid_o,
  output alu_pkg::alu_rsp_t             rsp_o
);
  import alu_pkg::*;

  word_t      operand_a;
  word_t      operand_b;
  logic [1:0] shnadd_amt;
  word_t      shnadd_result;
  word_t      orc_b_result;
  word_t      rev8_result;
  word_t      result_d;
  logic       fault_d;
  word_t      result_q;
  logic       cmp_q;
  logic       err_q;

  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;

  ////////////////////////////////////////////////////////////////////////////
  // Local small ops

  // SHnADD shifts A by 1, 2 or 3 before the add
  always_comb begin
    unique case (req_i.op)
      ALU_B_SH1ADD: shnadd_amt = 2'd1;
      ALU_B_SH2ADD: shnadd_amt = 2'd2;
      default:      shnadd_amt = 2'd3;
    endcase
  end

  assign shnadd_result = (operand_a << shnadd_amt) + operand_b;

  // Byte-wise OR-combine and byte reverse
  always_comb begin
    for (int b = 0; b < XLEN / 8; b++) begin
      orc_b_result[8*b +: 8] = {8{|operand_a[8*b +: 8]}};
      rev8_result[8*b +: 8]  = operand_a[8*(XLEN/8-1-b) +: 8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    // Branch-only and unknown opcodes give zero
    result_d = '0;
    unique case (req_i.op)
      ALU_AND:      result_d = operand_a & operand_b;
      ALU_OR:       result_d = operand_a | operand_b;
      ALU_XOR:      result_d = operand_a ^ operand_b;
      ALU_B_ANDN:   result_d = operand_a & ~operand_b;
      ALU_B_ORN:    result_d = operand_a | ~operand_b;
      ALU_B_XNOR:   result_d = operand_a ^ ~operand_b;
      ALU_ADD,
      ALU_SUB:      result_d = sum_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_B_ROL,
      ALU_B_ROR:    result_d = shift_result_i;
      // Single-bit ops exist only with Zbs
      ALU_B_BSET,
      ALU_B_BCLR,
      ALU_B_BINV,
      ALU_B_BEXT:   result_d = zbs_en ? shift_result_i : '0;
      ALU_SLT,
      ALU_SLTU:     result_d = word_t'(less_i);
      ALU_B_MIN,
      ALU_B_MINU:   result_d = min_i;
      ALU_B_MAX,
      ALU_B_MAXU:   result_d = max_i;
      ALU_B_SH1ADD,
      ALU_B_SH2ADD,
      ALU_B_SH3ADD: result_d = shnadd_result;
      ALU_B_CLZ,
      ALU_B_CTZ,
      ALU_B_CPOP:   result_d = word_t'(count_i);
      ALU_B_ORC_B:  result_d = orc_b_result;
      ALU_B_REV8:   result_d = rev8_result;
      ALU_B_SEXT_B: result_d = {{(XLEN-8){operand_a[7]}}, operand_a[7:0]};
      ALU_B_SEXT_H: result_d = {{(XLEN-16){operand_a[15]}}, operand_a[15:0]};
      ALU_B_ZEXT_H: result_d = {{(XLEN-16){1'b0}}, operand_a[15:0]};
      default: ;
    endcase
  end

  // Adder disagreement only counts when the adder result is used
  assign fault_d = mismatch_i && (req_i.op inside {ALU_ADD, ALU_SUB});

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  // Control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        err_q <= fault_d;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= result_d;
      cmp_q    <= cmp_result_i;
    end
  end

  assign rsp_o = '{result: result_q, cmp_result: cmp_q, alu_err: err_q};

  // No stale response right after reset
  assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else $error("valid_o high in the cycle after reset");

endmodule

//--- src/alu_shifter.sv
// Only the low 5 bits of operand B are used as the shift amount
// With zbs_en at 0 the single-bit opcodes pass the raw shift of A through
`timescale 1ns/1ps

module alu_shifter #(
  parameter bit zbs_en = 1'b1
) (
  input  alu_pkg::alu_op_e op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  output alu_pkg::word_t   shift_result_o
);
  import alu_pkg::*;

  logic              shift_right;
  logic [5:0]        shamt;
  word_t             shifter_aa;
  word_t             shifter_bb;
  logic [2*XLEN-1:0] funnel;
  word_t             funnel_lo;

  ////////////////////////////////////////////////////////////////////////////
  // Funnel setup

  // Right shifts become left rotates by the negated amount
  assign shift_right = op_i inside {ALU_SRL, ALU_SRA, ALU_B_ROR, ALU_B_BEXT};
  assign shamt = shift_right ? -{1'b0, operand_b_i[4:0]} : {1'b0, operand_b_i[4:0]};

  always_comb begin
    // Lower half is the data, upper half is what fills in
    shifter_aa = operand_a_i;
    shifter_bb = '0;
    unique case (op_i)
      // Sign fill from the left
      ALU_SRA: shifter_bb = {XLEN{operand_a_i[XLEN-1]}};
      // Rotates feed A back in
      ALU_B_ROL,
      ALU_B_ROR: shifter_bb = operand_a_i;
      // Walk a single one into the bit position
      ALU_B_BSET,
      ALU_B_BCLR,
      ALU_B_BINV: begin
        if (zbs_en) begin
          shifter_aa = word_t'(1);
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Six rotate stages over the 64-bit funnel

  always_comb begin
    funnel = {shifter_bb, shifter_aa};
    for (int s = 5; s >= 0; s--) begin
      if (shamt[s]) begin
        funnel = (funnel << (1 << s)) | (funnel >> (2 * XLEN - (1 << s)));
      end
    end
  end

  assign funnel_lo = funnel[XLEN-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Single-bit ops on top of the shifted mask

  generate
    if (zbs_en) begin : gen_zbs
      always_comb begin
        shift_result_o = funnel_lo;
        unique case (op_i)
          ALU_B_BEXT: shift_result_o = word_t'(funnel_lo[0]);
          ALU_B_BSET: shift_result_o = operand_a_i | funnel_lo;
          ALU_B_BCLR: shift_result_o = operand_a_i & ~funnel_lo;
          ALU_B_BINV: shift_result_o = operand_a_i ^ funnel_lo;
          default: ;
        endcase
      end
    end else begin : gen_no_zbs
      assign shift_result_o = funnel_lo;
    end
  endgenerate

  // Logical shifts must bring in zeros from the empty upper half
  always_comb begin
    if (op_i == ALU_SLL) begin
      assert (funnel_lo == (operand_a_i << operand_b_i[4:0]))
        else $error("zero fill wrong for logical left shift");
    end
    if (op_i == ALU_SRL) begin
      assert (funnel_lo == (operand_a_i >> operand_b_i[4:0]))
        else $error("zero fill wrong for logical right shift");
    end
  end

endmodule

//--- src/alu_top.sv
// Execute-stage ALU, result one cycle after each valid request
// zbs_en at 0 makes BSET, BCLR, BINV and BEXT return zero
`timescale 1ns/1ps

module alu_top #(
  parameter bit zbs_en = 1'b1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              valid_i,
  input  alu_pkg::alu_req_t req_i,
  output logic              valid_o,
  output alu_pkg::alu_rsp_t rsp_o
);
  import alu_pkg::*;

  // Unit outputs towards the result stage
  word_t            sum;
  logic             mismatch;
  word_t            shift_result;
  logic             cmp_result;
  logic             less;
  word_t            min_val;
  word_t            max_val;
  logic [CNT_W-1:0] count;

  alu_adder alu_adder_inst (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .sum_o       (sum),
    .mismatch_o  (mismatch)
  );

  alu_shifter #(
    .zbs_en (zbs_en)
  ) alu_shifter_inst (
    .op_i           (req_i.op),
    .operand_a_i    (req_i.operand_a),
    .operand_b_i    (req_i.operand_b),
    .shift_result_o (shift_result)
  );

  alu_compare alu_compare_inst (
    .op_i         (req_i.op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .cmp_result_o (cmp_result),
    .less_o       (less),
    .min_o        (min_val),
    .max_o        (max_val)
  );

  alu_bitcount alu_bitcount_inst (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .count_o     (count)
  );

  alu_result_stage #(
    .zbs_en (zbs_en)
  ) alu_result_stage_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .req_i          (req_i),
    .sum_i          (sum),
    .mismatch_i     (mismatch),
    .shift_result_i (shift_result),
    .cmp_result_i   (cmp_result),
    .less_i         (less),
    .min_i          (min_val),
    .max_i          (max_val),
    .count_i        (count),
    .valid_o        (valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

//--- verilog.f
src/alu_pkg.sv
src/alu_adder.sv
src/alu_shifter.sv
src/alu_compare.sv
src/alu_bitcount.sv
src/alu_result_stage.sv
src/alu_top.sv
sim/alu_tb.sv
